//--- build.f
+incdir+tests
source/cpu_pkg.sv
source/main_decoder.sv
source/alu_decoder.sv
source/imm_extend.sv
source/alu.sv
source/reg_file.sv
source/instr_mem.sv
source/data_mem.sv
source/riscv_cpu.sv
tests/tb_riscv_cpu.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_riscv_cpu -f build.f \
    && ./obj_dir/Vtb_riscv_cpu | tee /dev/stderr | grep -q "^Testbench passed$" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- source/alu.sv
module alu (
    input  logic                     clk,      // only samples the check below
    input  logic [cpu_pkg::xlen-1:0] a,
    input  logic [cpu_pkg::xlen-1:0] b,
    input  cpu_pkg::alu_ctrl_t       alu_ctrl,
    output logic [cpu_pkg::xlen-1:0] y,
    output logic                     zero      // y is all zeros, used as eq by beq
);
    import cpu_pkg::*;

    logic lt;                                  // signed less than

    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (alu_ctrl)
            alu_add: y = a + b;
            alu_sub: y = a - b;
            alu_and: y = a & b;
            alu_or:  y = a | b;
            alu_slt: y = {{(xlen-1){1'b0}}, lt};
            default: y = a + b;
        endcase
    end

    assign zero = (y == '0);

    // the decoder chain must always resolve to a real operation
    assert property (@(posedge clk) !$isunknown(alu_ctrl))
        else $error("alu_ctrl is unknown");

endmodule

//--- source/alu_decoder.sv
module alu_decoder (
    input  cpu_pkg::alu_op_t   alu_op,         // class of operation from the main decoder
    input  logic [2:0]         funct3,
    input  logic               funct7_5,       // instr bit 30, sub vs add on r-type
    input  logic               opcode_5,       // instr bit 5, set for r-type only here
    output cpu_pkg::alu_ctrl_t alu_ctrl
);
    import cpu_pkg::*;

    always_comb begin
        alu_ctrl = alu_add;                    // loads, stores, jalr and anything unknown
        case (alu_op)
            aluop_add: alu_ctrl = alu_add;
            aluop_sub: alu_ctrl = alu_sub;     // beq compare
            aluop_funct: begin
                case (funct3)
                    3'b000:  alu_ctrl = (funct7_5 && opcode_5) ? alu_sub : alu_add;  // addi never sub
                    3'b010:  alu_ctrl = alu_slt;
                    3'b110:  alu_ctrl = alu_or;
                    3'b111:  alu_ctrl = alu_and;
                    default: alu_ctrl = alu_add;   // shifts and xor not in the subset
                endcase
            end
            default: alu_ctrl = alu_add;
        endcase
    end

endmodule

//--- source/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen = 32;                  // data and address width, one word

    typedef enum logic [6:0] {
        op_load   = 7'd3,                      // lw
        op_imm    = 7'd19,                     // addi, andi, ori, slti
        op_store  = 7'd35,                     // sw
        op_r      = 7'd51,                     // add, sub, and, or, slt
        op_branch = 7'd99,                     // beq only
        op_jalr   = 7'd103,
        op_jal    = 7'd111
    } opcode_t;

    typedef enum logic [1:0] {
        res_alu,                               // alu result back to rd
        res_mem,                               // load data back to rd
        res_pc4                                // link address for jal and jalr
    } result_src_t;

    typedef enum logic [1:0] {imm_i, imm_s, imm_b, imm_j} imm_src_t;

    typedef enum logic [1:0] {aluop_add, aluop_sub, aluop_funct} alu_op_t;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt} alu_ctrl_t;

    typedef enum logic [1:0] {
        pc_plus4,                              // fall through
        pc_target,                             // pc plus immediate, beq and jal
        pc_alu                                 // rs1 plus immediate with bit 0 cleared, jalr
    } pc_src_t;

    // whole control word out of the main decoder, 11 bits
    typedef struct packed {
        pc_src_t     pc_src;
        result_src_t result_src;
        logic        mem_write;
        logic        alu_src;                  // 1 picks the immediate as alu operand b
        imm_src_t    imm_src;
        logic        reg_write;
        alu_op_t     alu_op;
    } ctrl_t;

endpackage

//--- source/data_mem.sv
module data_mem #(
    parameter int dmem_words = 64
) (
    input  logic                     clk,
    input  logic                     we,       // sw, gated by reset at the top
    input  logic [cpu_pkg::xlen-1:0] addr,     // byte address from the alu
    input  logic [cpu_pkg::xlen-1:0] wdata,
    output logic [cpu_pkg::xlen-1:0] rdata
);

    localparam int aw = $clog2(dmem_words);

    logic [cpu_pkg::xlen-1:0] mem [dmem_words];  // contents survive reset
    logic [aw-1:0]            idx;

    assign idx   = addr[aw+1:2];               // drop the byte offset
    assign rdata = mem[idx];                   // lw sees it in the same cycle

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    // only whole words are stored, so the program must keep addresses aligned
    assert property (@(posedge clk) we |-> (addr[1:0] == 2'b00))
        else $error("misaligned store to data memory");

endmodule

//--- source/imm_extend.sv
module imm_extend (
    input  logic [cpu_pkg::xlen-1:0] instr,
    input  cpu_pkg::imm_src_t        imm_src,
    output logic [cpu_pkg::xlen-1:0] imm       // sign extended from instr bit 31
);
    import cpu_pkg::*;

    always_comb begin
        case (imm_src)
            imm_i: imm = {{20{instr[31]}}, instr[31:20]};               // addi, lw, jalr
            imm_s: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};  // sw
            imm_b: begin
                // branch offset, halfword aligned
                imm = {{19{instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};
            end
            imm_j: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};                  // jal, +-1 MiB
            end
            default: imm = '0;
        endcase
    end

endmodule

//--- source/instr_mem.sv
module instr_mem #(
    parameter int imem_words = 64
) (
    input  logic                     clk,
    input  logic                     load_en,    // program load, only while reset is high
    input  logic [cpu_pkg::xlen-1:0] load_addr,  // word index, not a byte address
    input  logic [cpu_pkg::xlen-1:0] load_data,
    input  logic [cpu_pkg::xlen-1:0] addr,       // byte address from the pc
    output logic [cpu_pkg::xlen-1:0] instr
);

    localparam int aw = $clog2(imem_words);

    logic [cpu_pkg::xlen-1:0] mem [imem_words];

    assign instr = mem[addr[aw+1:2]];           // word aligned fetch, no latency

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[aw-1:0]] <= load_data;
        end
    end

    assert property (@(posedge clk) load_en |-> (load_addr < imem_words))
        else $error("program load past end of instruction memory");

endmodule

//--- source/main_decoder.sv
module main_decoder (
    input  cpu_pkg::opcode_t opcode,           // instruction bits 6:0
    input  logic             eq,               // alu zero flag, operands equal for beq
    output cpu_pkg::ctrl_t   ctrl              // every control field for this instruction
);
    import cpu_pkg::*;

    always_comb begin
        // safe defaults, an unknown opcode writes nothing and falls through
        ctrl.pc_src     = pc_plus4;
        ctrl.result_src = res_alu;
        ctrl.mem_write  = 1'b0;
        ctrl.alu_src    = 1'b0;
        ctrl.imm_src    = imm_i;
        ctrl.reg_write  = 1'b0;
        ctrl.alu_op     = aluop_add;

        case (opcode)
            op_r: begin
                ctrl.reg_write = 1'b1;         // rs1 op rs2 into rd
                ctrl.alu_op    = aluop_funct;
            end
            op_imm: begin
                ctrl.alu_src   = 1'b1;         // rs1 op imm
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = aluop_funct;
            end
            op_load: begin
                ctrl.result_src = res_mem;
                ctrl.alu_src    = 1'b1;        // address is rs1 + imm
                ctrl.reg_write  = 1'b1;
            end
            op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.imm_src   = imm_s;        // split immediate
            end
            op_branch: begin
                ctrl.pc_src  = eq ? pc_target : pc_plus4;   // taken only when rs1 == rs2
                ctrl.imm_src = imm_b;
                ctrl.alu_op  = aluop_sub;      // compare by subtraction
            end
            op_jal: begin
                ctrl.pc_src     = pc_target;
                ctrl.result_src = res_pc4;     // link
                ctrl.imm_src    = imm_j;
                ctrl.reg_write  = 1'b1;
            end
            op_jalr: begin
                ctrl.pc_src     = pc_alu;      // target comes out of the alu
                ctrl.result_src = res_pc4;
                ctrl.alu_src    = 1'b1;
                ctrl.imm_src    = imm_i;       // jalr takes the i-type immediate
                ctrl.reg_write  = 1'b1;
            end
            default: begin
                ctrl.pc_src = pc_plus4;        // nop
            end
        endcase
    end

endmodule

//--- source/reg_file.sv
module reg_file (
    input  logic                     clk,
    input  logic                     we,       // already gated by reset at the top
    input  logic [4:0]               ra1,      // rs1
    input  logic [4:0]               ra2,      // rs2
    input  logic [4:0]               wa,       // rd
    input  logic [cpu_pkg::xlen-1:0] wd,
    output logic [cpu_pkg::xlen-1:0] rd1,
    output logic [cpu_pkg::xlen-1:0] rd2
);

    logic [cpu_pkg::xlen-1:0] regs [32];       // x0 entry exists but is never read

    // x0 reads as zero whatever the array holds
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

    always_ff @(posedge clk) begin
        if (we && (wa != 5'd0)) begin         // writes to x0 are dropped
            regs[wa] <= wd;
        end
    end

    // a committed write must carry a real destination and value from the datapath
    assert property (@(posedge clk) we |-> !$isunknown({wa, wd}))
        else $error("register write with unknown address or data");

endmodule

//--- source/riscv_cpu.sv
module riscv_cpu #(
    parameter int imem_words = 64,
    parameter int dmem_words = 64
) (
    input  logic                     clk,
    input  logic                     reset,      // sync, active high
    input  logic                     load_en,    // program load port, used during reset
    input  logic [cpu_pkg::xlen-1:0] load_addr,
    input  logic [cpu_pkg::xlen-1:0] load_data,
    output logic [cpu_pkg::xlen-1:0] retire_pc,  // pc of the instruction in this cycle
    output logic                     wb_en,
    output logic [4:0]               wb_addr,
    output logic [cpu_pkg::xlen-1:0] wb_data,
    output logic                     dmem_we,
    output logic [cpu_pkg::xlen-1:0] dmem_addr,
    output logic [cpu_pkg::xlen-1:0] dmem_wdata
);
    import cpu_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] pc_plus4_val;
    logic [xlen-1:0] pc_target_val;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] alu_y;
    logic [xlen-1:0] mem_rdata;
    logic [xlen-1:0] result;
    logic            zero;
    logic            reg_we;
    logic            mem_we;
    opcode_t         opcode;
    ctrl_t           ctrl;
    alu_ctrl_t       alu_ctrl;

    // program counter, one instruction per clock
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;                          // first fetch after reset is at 0
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_plus4_val  = pc + 32'd4;
    assign pc_target_val = pc + imm;           // beq and jal

    always_comb begin
        case (ctrl.pc_src)
            pc_target: pc_next = pc_target_val;
            pc_alu:    pc_next = {alu_y[xlen-1:1], 1'b0};  // jalr clears bit 0
            default:   pc_next = pc_plus4_val;
        endcase
    end

    instr_mem #(.imem_words(imem_words)) u_imem (
        .clk(clk), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .addr(pc), .instr(instr)
    );

    assign opcode = opcode_t'(instr[6:0]);

    main_decoder u_main_dec (.opcode(opcode), .eq(zero), .ctrl(ctrl));

    alu_decoder u_alu_dec (
        .alu_op(ctrl.alu_op), .funct3(instr[14:12]), .funct7_5(instr[30]),
        .opcode_5(instr[5]), .alu_ctrl(alu_ctrl)
    );

    imm_extend u_imm (.instr(instr), .imm_src(ctrl.imm_src), .imm(imm));

    // no architectural writes while reset holds
    assign reg_we = ctrl.reg_write && !reset;
    assign mem_we = ctrl.mem_write && !reset;

    reg_file u_regs (
        .clk(clk), .we(reg_we), .ra1(instr[19:15]), .ra2(instr[24:20]),
        .wa(instr[11:7]), .wd(result), .rd1(rd1), .rd2(rd2)
    );

    assign src_b = ctrl.alu_src ? imm : rd2;   // immediate or rs2

    alu u_alu (.clk(clk), .a(rd1), .b(src_b), .alu_ctrl(alu_ctrl), .y(alu_y), .zero(zero));

    data_mem #(.dmem_words(dmem_words)) u_dmem (
        .clk(clk), .we(mem_we), .addr(alu_y), .wdata(rd2), .rdata(mem_rdata)
    );

    // write-back select
    always_comb begin
        case (ctrl.result_src)
            res_mem: result = mem_rdata;
            res_pc4: result = pc_plus4_val;    // link address
            default: result = alu_y;
        endcase
    end

    // observation ports for the current instruction
    assign retire_pc  = pc;
    assign wb_en      = reg_we;
    assign wb_addr    = instr[11:7];
    assign wb_data    = result;
    assign dmem_we    = mem_we;
    assign dmem_addr  = alu_y;
    assign dmem_wdata = rd2;

endmodule

//--- tests/cpu_test_tasks.svh
// rv32i encoders, fields in manual order with the opcode in bits 6:0
function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return i_type(imm, rs1, 3'b000, rd, 7'b0010011);
endfunction

function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};   // sw
endfunction

function automatic logic [31:0] beq(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] jal(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

task automatic arith_ops();
    logic [11:0] a12;
    logic [11:0] b12;
    logic [31:0] a;
    logic [31:0] b;
    test_name = "arith";
    a12 = random_imm12();
    b12 = random_imm12();
    a   = {{20{a12[11]}}, a12};
    b   = {{20{b12[11]}}, b12};
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, a12));
    prog.push_back(addi(5'd2, 5'd0, b12));
    prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));   // add x3
    prog.push_back(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));   // sub x4
    prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));   // and x5
    prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));   // or x6
    prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd7));   // slt x7
    load_and_release();
    retire(32'd0, 1'b1, 5'd1, a);
    retire(32'd4, 1'b1, 5'd2, b);
    retire(32'd8, 1'b1, 5'd3, a + b);
    retire(32'd12, 1'b1, 5'd4, a - b);
    retire(32'd16, 1'b1, 5'd5, a & b);
    retire(32'd20, 1'b1, 5'd6, a | b);
    retire(32'd24, 1'b1, 5'd7, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
endtask

task automatic load_store();
    logic [11:0] v12;
    logic [31:0] v;
    test_name = "memory";
    v12 = random_imm12();
    v   = {{20{v12[11]}}, v12};
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, 12'd40));                       // base address
    prog.push_back(addi(5'd2, 5'd0, v12));
    prog.push_back(s_type(12'd8, 5'd2, 5'd1));                      // sw x2, 8(x1)
    prog.push_back(i_type(12'd8, 5'd1, 3'b010, 5'd3, 7'b0000011));  // lw x3, 8(x1)
    prog.push_back(addi(5'd0, 5'd0, 12'd123));                      // aimed at x0
    prog.push_back(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd4));        // add x4, x0, x0
    load_and_release();
    retire(32'd0, 1'b1, 5'd1, 32'd40);
    retire(32'd4, 1'b1, 5'd2, v);
    store_retire(32'd8, 32'd48, v);
    retire(32'd12, 1'b1, 5'd3, v);
    retire(32'd16, 1'b1, 5'd0, 32'd123);       // enable still shows, x0 keeps zero
    retire(32'd20, 1'b1, 5'd4, 32'd0);
endtask

task automatic beq_branch();
    test_name = "branch";
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, 12'd5));
    prog.push_back(addi(5'd2, 5'd0, 12'd5));
    prog.push_back(beq(13'd8, 5'd2, 5'd1));    // equal, jumps over pc 12
    prog.push_back(addi(5'd3, 5'd0, 12'd1));
    prog.push_back(addi(5'd3, 5'd0, 12'd2));
    prog.push_back(beq(13'd8, 5'd0, 5'd1));    // 5 against x0, falls through
    prog.push_back(addi(5'd4, 5'd0, 12'd3));
    load_and_release();
    retire(32'd0, 1'b1, 5'd1, 32'd5);
    retire(32'd4, 1'b1, 5'd2, 32'd5);
    retire(32'd8, 1'b0, 5'd0, 32'd0);
    retire(32'd16, 1'b1, 5'd3, 32'd2);
    retire(32'd20, 1'b0, 5'd0, 32'd0);
    retire(32'd24, 1'b1, 5'd4, 32'd3);
endtask

task automatic jump_link();
    logic [31:0] target;
    test_name = "jump";
    target = (32'd24 + 32'd5) & ~32'd1;        // rs1 plus imm with bit 0 cleared
    prog.delete();
    prog.push_back(jal(21'd12, 5'd1));
    prog.push_back(addi(5'd5, 5'd0, 12'd1));
    prog.push_back(addi(5'd5, 5'd0, 12'd2));
    prog.push_back(addi(5'd2, 5'd0, 12'd24));
    prog.push_back(i_type(12'd5, 5'd2, 3'b000, 5'd3, 7'b1100111));  // jalr x3, 5(x2)
    prog.push_back(addi(5'd5, 5'd0, 12'd3));
    prog.push_back(addi(5'd5, 5'd0, 12'd4));
    prog.push_back(addi(5'd6, 5'd0, 12'd7));
    load_and_release();
    retire(32'd0, 1'b1, 5'd1, 32'd4);
    retire(32'd12, 1'b1, 5'd2, 32'd24);
    retire(32'd16, 1'b1, 5'd3, 32'd20);
    retire(target, 1'b1, 5'd6, 32'd7);
endtask

task automatic reset_and_nop();
    test_name = "reset";
    prog.delete();
    prog.push_back(s_type(12'd4, 5'd0, 5'd0)); // sw x0 to address 4 sits at pc 0 during the load
    prog.push_back(32'h0000_0f8b);             // custom-0 opcode, rd field x31
    prog.push_back(32'h0000_0fff);             // opcode 7'h7f
    prog.push_back(addi(5'd7, 5'd0, 12'd9));
    load_and_release();
    store_retire(32'd0, 32'd4, 32'd0);
    retire(32'd4, 1'b0, 5'd0, 32'd0);
    retire(32'd8, 1'b0, 5'd0, 32'd0);
    retire(32'd12, 1'b1, 5'd7, 32'd9);
endtask

//--- tests/tb_riscv_cpu.sv
module tb_riscv_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_cycles = 2000;          // all programs together run in under 100 cycles

    logic        clk;
    logic        reset;
    logic        load_en;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic [31:0] retire_pc;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] prog [$];                     // program words, queue index is the word address
    logic [31:0] lfsr_state;
    string       test_name;
    int          error_count;
    int          check_count;
    int          cycle_count;

    riscv_cpu #(.imem_words(64), .dmem_words(64)) UUT (
        .clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .retire_pc(retire_pc), .wb_en(wb_en), .wb_addr(wb_addr),
        .wb_data(wb_data), .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                // 20 ns period
    end

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [11:0] random_imm12();
        logic [11:0] v;
        v = '0;
        for (int k = 0; k < 12; k++) begin
            v          = {v[10:0], lfsr_state[0]};   // one step per bit taken
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        assert (act === exp) else begin
            error_count++;
            $display("[ERROR] %s: %s expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // program goes in under reset, the pc sits at 0 until reset drops
    task automatic load_and_release();
        foreach (prog[i]) begin
            @(posedge clk);
            #2;
            reset     = 1'b1;
            load_en   = 1'b1;
            load_addr = i;
            load_data = prog[i];
            @(negedge clk);
            compare("wb_en in reset", 32'd0, {31'd0, wb_en});
            compare("dmem_we in reset", 32'd0, {31'd0, dmem_we});
        end
        @(posedge clk);                        // last word stored at this edge
        #2;
        reset   = 1'b0;
        load_en = 1'b0;
    endtask

    // one instruction per cycle, outputs are settled by the falling edge
    task automatic retire(input logic [31:0] pc, input logic wb, input logic [4:0] rd,
                          input logic [31:0] data);
        @(negedge clk);
        compare("retire_pc", pc, retire_pc);
        compare("wb_en", {31'd0, wb}, {31'd0, wb_en});
        compare("dmem_we", 32'd0, {31'd0, dmem_we});
        if (wb) begin
            compare("wb_addr", {27'd0, rd}, {27'd0, wb_addr});
            compare("wb_data", data, wb_data);
        end
    endtask

    task automatic store_retire(input logic [31:0] pc, input logic [31:0] addr,
                                input logic [31:0] data);
        @(negedge clk);
        compare("retire_pc", pc, retire_pc);
        compare("wb_en", 32'd0, {31'd0, wb_en});
        compare("dmem_we", 32'd1, {31'd0, dmem_we});
        compare("dmem_addr", addr, dmem_addr);
        compare("dmem_wdata", data, dmem_wdata);
    endtask

    `include "cpu_test_tasks.svh"

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, the programs did not finish within %0d cycles", max_cycles);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        lfsr_state  = 32'hd8537e42;
        error_count = 0;
        check_count = 0;
        test_name   = "reset";
        repeat (2) @(posedge clk);             // two cycles of reset before the first load
        arith_ops();
        load_store();
        beq_branch();
        jump_link();
        reset_and_nop();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
